/* rtl/umi_apb_pkg.sv */
// UMI to APB bridge shared package with command layout, opcodes and request classes
`default_nettype none

package umi_apb_pkg;

    // ##########################################################################
    // UMI command layout
    // ##########################################################################

    localparam int CW = 32;                 // UMI command width

    typedef struct packed {
        logic [2:0] hostid;                 // Host ID
        logic [1:0] err;                    // Error code
        logic [1:0] user;                   // User bits
        logic       ex;                     // Exclusive access
        logic       eof;                    // End of frame
        logic       eom;                    // End of message
        logic [1:0] prot;                   // Protection
        logic [3:0] qos;                    // Quality of service
        logic [7:0] len;                    // Transfer count minus one
        logic [2:0] size;                   // Log2 of word bytes
        logic [4:0] opcode;                 // Command opcode, low bits
    } umi_cmd_t;

    // ##########################################################################
    // Opcodes
    // ##########################################################################

    localparam logic [4:0] UMI_REQ_READ   = 5'd1;   // Read request
    localparam logic [4:0] UMI_REQ_WRITE  = 5'd3;   // Write with ack
    localparam logic [4:0] UMI_REQ_POSTED = 5'd5;   // Posted write
    localparam logic [4:0] UMI_REQ_RDMA   = 5'd7;   // Remote DMA
    localparam logic [4:0] UMI_REQ_ATOMIC = 5'd9;   // Atomic op
    localparam logic [4:0] UMI_RESP_READ  = 5'd2;   // Read data back
    localparam logic [4:0] UMI_RESP_WRITE = 5'd4;   // Write ack

    // Request class carried down the pipe
    typedef enum logic [1:0] {
        CLASS_READ,                         // Needs read response
        CLASS_WRITE,                        // Needs write ack
        CLASS_POSTED                        // No response
    } req_class_t;

endpackage : umi_apb_pkg

`default_nettype wire

/* rtl/umi_bridge_if.sv */
// Bridge-internal links from decode to execute and from execute to result
`timescale 1ns/1ps
`default_nettype none

// Decoded request waiting for the APB engine
interface apb_req_if
    import umi_apb_pkg::*;
#(
    parameter int APB_AW = 64,              // APB address width
    parameter int RW     = 64               // Register width
) ();
    logic              pend;                // Request waiting
    req_class_t        cls;                 // Read, write or posted
    logic [APB_AW-1:0] addr;                // Register address
    logic [RW-1:0]     wdata;               // Write data
    logic [1:0]        prot;                // UMI protection bits
    logic              take;                // Pulse, request consumed

    modport decode  (output pend, cls, addr, wdata, prot, input take);
    modport execute (input pend, cls, addr, wdata, prot, output take);
endinterface : apb_req_if

// Finished APB transfer handed to the response builder
interface apb_done_if
    import umi_apb_pkg::*;
#(
    parameter int RW = 64                   // Register width
) ();
    logic          done;                    // Pulse, transfer finished
    req_class_t    cls;                     // Class of finished request
    logic [RW-1:0] rdata;                   // Captured prdata
    logic          slverr;                  // Captured pslverr
    logic          busy;                    // Response pending downstream

    modport execute (output done, cls, rdata, slverr, input busy);
    modport result  (input done, cls, rdata, slverr, output busy);
endinterface : apb_done_if

`default_nettype wire

/* rtl/umi_req_decode.sv */
// UMI request decode stage with group check, opcode classification and holding register
`timescale 1ns/1ps
`default_nettype none

module umi_req_decode
    import umi_apb_pkg::*;
#(
    parameter int AW        = 64,           // UMI address width
    parameter int DW        = 256,          // UMI data width
    parameter int RW        = 64,           // Register width
    parameter int APB_AW    = 64,           // APB address width
    parameter int GRPOFFSET = 24,           // Group field position
    parameter int GRPAW     = 0,            // Group field width where 0 disables
    parameter int GRPID     = 0             // Expected group
) (
    input  logic          clk,
    input  logic          nreset,
    input  logic          req_valid,
    input  umi_cmd_t      req_cmd,
    input  logic [AW-1:0] req_dstaddr,
    input  logic [AW-1:0] req_srcaddr,
    input  logic [DW-1:0] req_data,
    output logic          req_ready,
    apb_req_if.decode     req,
    output umi_cmd_t      saved_cmd,
    output logic [AW-1:0] saved_dstaddr,
    output logic [AW-1:0] saved_srcaddr
);
    logic          ready_en;                // Low for one cycle out of reset
    logic          pend_r;
    logic          accept;
    logic          group_match;
    logic          cls_ok;                  // Opcode we can serve
    req_class_t    cls_next;
    req_class_t    cls_r;
    umi_cmd_t      cmd_r;
    logic [AW-1:0] dst_r;
    logic [AW-1:0] src_r;
    logic [RW-1:0] data_r;

    if (GRPAW > 0) begin : g_grp
        assign group_match = (req_dstaddr[GRPOFFSET +: GRPAW] == GRPAW'(GRPID));
    end else begin : g_nogrp
        assign group_match = 1'b1;          // Check disabled
    end

    always_comb begin
        cls_ok   = 1'b0;
        cls_next = CLASS_READ;
        case (req_cmd.opcode)
            UMI_REQ_READ: begin
                cls_ok   = 1'b1;
                cls_next = CLASS_READ;
            end
            UMI_REQ_WRITE: begin
                cls_ok   = 1'b1;
                cls_next = CLASS_WRITE;
            end
            UMI_REQ_POSTED: begin
                cls_ok   = 1'b1;
                cls_next = CLASS_POSTED;
            end
            UMI_REQ_RDMA:   cls_ok = 1'b0;  // Accepted then dropped
            UMI_REQ_ATOMIC: cls_ok = 1'b0;  // Accepted then dropped
            default:        cls_ok = 1'b0;  // Unknown opcode dropped
        endcase
    end

    // Free when empty or being taken this cycle
    assign req_ready = ready_en & (~pend_r | req.take);
    assign accept    = req_valid & req_ready;

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            ready_en <= 1'b0;
            pend_r   <= 1'b0;
        end else begin
            ready_en <= 1'b1;
            if (accept)
                pend_r <= cls_ok & group_match; // Drops never set pend
            else if (req.take)
                pend_r <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cls_r  <= cls_next;
            cmd_r  <= req_cmd;
            dst_r  <= req_dstaddr;
            src_r  <= req_srcaddr;
            data_r <= req_data[RW-1:0];     // Low register lane only
        end
        if (req.take) begin                 // Keep response fields for result
            saved_cmd     <= cmd_r;
            saved_dstaddr <= dst_r;
            saved_srcaddr <= src_r;
        end
    end

    assign req.pend  = pend_r;
    assign req.cls   = cls_r;
    assign req.addr  = dst_r[APB_AW-1:0];
    assign req.wdata = data_r;
    assign req.prot  = cmd_r.prot;

    a_pend_hold : assert property (@(posedge clk) disable iff (!nreset)
        $fell(req.pend) |-> $past(req.take))
        else $error("pend dropped without take");

endmodule : umi_req_decode

`default_nettype wire

/* rtl/apb_access.sv */
// APB execute stage running setup and access phases for one decoded request
`timescale 1ns/1ps
`default_nettype none

module apb_access
    import umi_apb_pkg::*;
#(
    parameter int RW     = 64,              // Register width
    parameter int APB_AW = 64               // APB address width
) (
    input  logic              clk,
    input  logic              nreset,
    apb_req_if.execute        req,
    apb_done_if.execute       done_if,
    output logic [APB_AW-1:0] paddr,
    output logic [2:0]        pprot,
    output logic              psel,
    output logic              penable,
    output logic              pwrite,
    output logic [RW-1:0]     pwdata,
    output logic [RW/8-1:0]   pstrb,
    input  logic              pready,
    input  logic [RW-1:0]     prdata,
    input  logic              pslverr
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS
    } apb_state_t;

    apb_state_t        state;
    logic              complete;            // Access phase ends this edge
    logic              start;               // Launch setup next cycle
    req_class_t        cls_r;               // Class of running transfer
    req_class_t        done_cls_r;          // Class of finished transfer
    logic              done_r;
    logic [RW-1:0]     rdata_r;
    logic              slverr_r;
    logic [APB_AW-1:0] paddr_r;
    logic [RW-1:0]     pwdata_r;
    logic              pwrite_r;
    logic [2:0]        pprot_r;

    assign complete = (state == ST_ACCESS) && pready;

    // Back-to-back only after a posted write, which leaves no response
    assign start = req.pend && !done_if.busy &&
                   ((state == ST_IDLE) || (complete && cls_r == CLASS_POSTED));

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            state  <= ST_IDLE;
            done_r <= 1'b0;
        end else begin
            done_r <= complete;
            case (state)
                ST_IDLE:   if (start) state <= ST_SETUP;
                ST_SETUP:  state <= ST_ACCESS;
                ST_ACCESS: if (complete) state <= start ? ST_SETUP : ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    // ##########################################################################
    // Transfer fields held from setup to completion
    // ##########################################################################

    always_ff @(posedge clk) begin
        if (start) begin
            cls_r    <= req.cls;
            paddr_r  <= req.addr;
            pwdata_r <= req.wdata;
            pwrite_r <= (req.cls != CLASS_READ);
            pprot_r  <= {1'b0, req.prot};   // Top bit always data access
        end
        if (complete) begin
            rdata_r    <= prdata;
            slverr_r   <= pslverr;
            done_cls_r <= cls_r;
        end
    end

    assign paddr   = paddr_r;
    assign pwdata  = pwdata_r;
    assign pwrite  = pwrite_r;
    assign pprot   = pprot_r;
    assign pstrb   = '1;                    // Full register writes only
    assign psel    = (state != ST_IDLE);
    assign penable = (state == ST_ACCESS);

    assign req.take       = (state == ST_SETUP); // First setup cycle
    assign done_if.done   = done_r;
    assign done_if.cls    = done_cls_r;
    assign done_if.rdata  = rdata_r;
    assign done_if.slverr = slverr_r;

    // Access phase only ever follows a selected cycle
    a_enable_sel : assert property (@(posedge clk) disable iff (!nreset)
        penable |-> psel && $past(psel))
        else $error("penable without setup phase");

    a_addr_stable : assert property (@(posedge clk) disable iff (!nreset)
        penable |-> $stable(paddr) && $stable(pwrite))
        else $error("paddr or pwrite changed during transfer");

endmodule : apb_access

`default_nettype wire

/* rtl/umi_resp_pack.sv */
// UMI response builder holding one read or write response until accepted
`timescale 1ns/1ps
`default_nettype none

module umi_resp_pack
    import umi_apb_pkg::*;
#(
    parameter int AW = 64,                  // UMI address width
    parameter int DW = 256,                 // UMI data width
    parameter int RW = 64                   // Register width
) (
    input  logic          clk,
    input  logic          nreset,
    apb_done_if.result    done_if,
    input  umi_cmd_t      saved_cmd,
    input  logic [AW-1:0] saved_dstaddr,
    input  logic [AW-1:0] saved_srcaddr,
    output logic          resp_valid,
    output umi_cmd_t      resp_cmd,
    output logic [AW-1:0] resp_dstaddr,
    output logic [AW-1:0] resp_srcaddr,
    output logic [DW-1:0] resp_data,
    input  logic          resp_ready
);
    logic          load;                    // Response due this edge
    logic          valid_r;
    umi_cmd_t      cmd_next;
    umi_cmd_t      cmd_r;
    logic [AW-1:0] dst_r;
    logic [AW-1:0] src_r;
    logic [DW-1:0] data_r;

    assign load = done_if.done && (done_if.cls != CLASS_POSTED);

    always_comb begin
        cmd_next        = saved_cmd;        // Keep size, len, qos and the rest
        cmd_next.opcode = (done_if.cls == CLASS_READ) ? UMI_RESP_READ : UMI_RESP_WRITE;
        cmd_next.err    = done_if.slverr ? 2'b10 : 2'b00;
    end

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset)
            valid_r <= 1'b0;
        else if (load)
            valid_r <= 1'b1;
        else if (resp_ready)
            valid_r <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (load) begin
            cmd_r  <= cmd_next;
            dst_r  <= saved_srcaddr;        // Reply goes back to requester
            src_r  <= saved_dstaddr;
            data_r <= (done_if.cls == CLASS_READ) ? DW'(done_if.rdata) : '0;
        end
    end

    // Also covers the done cycle so execute cannot overrun the slot
    assign done_if.busy = valid_r | load;

    assign resp_valid   = valid_r;
    assign resp_cmd     = cmd_r;
    assign resp_dstaddr = dst_r;
    assign resp_srcaddr = src_r;
    assign resp_data    = data_r;

    a_resp_hold : assert property (@(posedge clk) disable iff (!nreset)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_cmd))
        else $error("response changed under back-pressure");

endmodule : umi_resp_pack

`default_nettype wire

/* rtl/umi_apb_bridge.sv */
// UMI device port to APB requester bridge top level
`timescale 1ns/1ps
`default_nettype none

module umi_apb_bridge
    import umi_apb_pkg::*;
#(
    parameter int AW        = 64,           // UMI address width
    parameter int DW        = 256,          // UMI data width
    parameter int RW        = 64,           // Register width
    parameter int APB_AW    = 64,           // APB address width
    parameter int GRPOFFSET = 24,           // Group field position
    parameter int GRPAW     = 0,            // Group field width, 0 disables
    parameter int GRPID     = 0             // Expected group
) (
    input  logic              clk,
    input  logic              nreset,
    // UMI request
    input  logic              req_valid,
    input  logic [CW-1:0]     req_cmd,
    input  logic [AW-1:0]     req_dstaddr,
    input  logic [AW-1:0]     req_srcaddr,
    input  logic [DW-1:0]     req_data,
    output logic              req_ready,
    // UMI response
    output logic              resp_valid,
    output logic [CW-1:0]     resp_cmd,
    output logic [AW-1:0]     resp_dstaddr,
    output logic [AW-1:0]     resp_srcaddr,
    output logic [DW-1:0]     resp_data,
    input  logic              resp_ready,
    // APB requester
    output logic [APB_AW-1:0] paddr,
    output logic [2:0]        pprot,
    output logic              psel,
    output logic              penable,
    output logic              pwrite,
    output logic [RW-1:0]     pwdata,
    output logic [RW/8-1:0]   pstrb,
    input  logic              pready,
    input  logic [RW-1:0]     prdata,
    input  logic              pslverr
);
    umi_cmd_t      saved_cmd;               // Fields of request in flight
    logic [AW-1:0] saved_dstaddr;
    logic [AW-1:0] saved_srcaddr;

    apb_req_if  #(.APB_AW(APB_AW), .RW(RW)) req_bus ();
    apb_done_if #(.RW(RW))                  done_bus ();

    umi_req_decode #(
        .AW(AW), .DW(DW), .RW(RW), .APB_AW(APB_AW),
        .GRPOFFSET(GRPOFFSET), .GRPAW(GRPAW), .GRPID(GRPID)
    ) u_decode (
        .clk(clk), .nreset(nreset),
        .req_valid(req_valid), .req_cmd(req_cmd),
        .req_dstaddr(req_dstaddr), .req_srcaddr(req_srcaddr),
        .req_data(req_data), .req_ready(req_ready),
        .req(req_bus.decode),
        .saved_cmd(saved_cmd), .saved_dstaddr(saved_dstaddr),
        .saved_srcaddr(saved_srcaddr)
    );

    apb_access #(.RW(RW), .APB_AW(APB_AW)) u_access (
        .clk(clk), .nreset(nreset),
        .req(req_bus.execute), .done_if(done_bus.execute),
        .paddr(paddr), .pprot(pprot), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .pstrb(pstrb),
        .pready(pready), .prdata(prdata), .pslverr(pslverr)
    );

    umi_resp_pack #(.AW(AW), .DW(DW), .RW(RW)) u_resp (
        .clk(clk), .nreset(nreset),
        .done_if(done_bus.result),
        .saved_cmd(saved_cmd), .saved_dstaddr(saved_dstaddr),
        .saved_srcaddr(saved_srcaddr),
        .resp_valid(resp_valid), .resp_cmd(resp_cmd),
        .resp_dstaddr(resp_dstaddr), .resp_srcaddr(resp_srcaddr),
        .resp_data(resp_data), .resp_ready(resp_ready)
    );

endmodule : umi_apb_bridge

`default_nettype wire

/* testbench/apb_reg_model.sv */
// APB completer model with sixteen registers, programmable wait states and error injection
`timescale 1ns/1ps
`default_nettype none

module apb_reg_model #(
    parameter int AW = 32,                  // APB address width
    parameter int RW = 64                   // Register width in multiples of 16
) (
    input  logic            clk,
    input  logic            nreset,
    input  logic [3:0]      wait_states,    // Access cycles before pready
    input  logic [AW-1:0]   paddr,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic [RW-1:0]   pwdata,
    input  logic [RW/8-1:0] pstrb,
    output logic            pready,
    output logic [RW-1:0]   prdata,
    output logic            pslverr
);
    logic [RW-1:0] regs [16];
    logic [3:0]    wait_cnt;                // Wait states spent so far
    logic [3:0]    idx;
    logic          bad;
    logic          access;

    // Reset contents tag each word with its own index
    function automatic logic [RW-1:0] fill(input logic [3:0] i);
        return {RW/16{12'hA5C, i}};
    endfunction

    assign idx     = paddr[6:3];            // Word index
    assign bad     = paddr[7];              // Error window
    assign access  = psel & penable;
    assign pready  = access & (wait_cnt == wait_states);
    assign pslverr = pready & bad;
    assign prdata  = (pready && !bad) ? regs[idx] : '0; // Old word shows on writes too

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            wait_cnt <= '0;
            for (int i = 0; i < 16; i++)
                regs[i] <= fill(4'(i));
        end else begin
            if (access && !pready)
                wait_cnt <= wait_cnt + 1'b1;
            else
                wait_cnt <= '0;             // Restart for next access
            if (pready && pwrite && !bad) begin // Failed writes leave state alone
                for (int b = 0; b < RW/8; b++)  // Byte lanes under pstrb
                    if (pstrb[b])
                        regs[idx][8*b +: 8] <= pwdata[8*b +: 8];
            end
        end
    end

endmodule : apb_reg_model

`default_nettype wire

/* testbench/tb_umi_apb_bridge.sv */
// Directed testbench for the UMI to APB bridge against a register model
`timescale 1ns/1ps
`default_nettype none

module tb_umi_apb_bridge
    import umi_apb_pkg::*;
();
    localparam int AW      = 64;
    localparam int DW      = 128;
    localparam int RW      = 64;
    localparam int APB_AW  = 32;
    localparam int TIMEOUT = 200;                               // Cycles per wait
    localparam logic [AW-1:0] BASE  = 64'h0000_0000_0500_0000;  // Group 5 matches
    localparam logic [AW-1:0] OTHER = 64'h0000_0000_0300_0000;  // Group 3 is dropped
    localparam logic [AW-1:0] HOST  = 64'h0000_0012_3400_0040;  // Requester address
    localparam logic [1:0]    PROT  = 2'b01;                    // Request protection

    logic              clk;
    logic              nreset;
    logic              req_valid;
    umi_cmd_t          req_cmd;
    logic [AW-1:0]     req_dstaddr;
    logic [AW-1:0]     req_srcaddr;
    logic [DW-1:0]     req_data;
    logic              req_ready;
    logic              resp_valid;
    umi_cmd_t          resp_cmd;
    logic [AW-1:0]     resp_dstaddr;
    logic [AW-1:0]     resp_srcaddr;
    logic [DW-1:0]     resp_data;
    logic              resp_ready;
    logic [APB_AW-1:0] paddr;
    logic [2:0]        pprot;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [RW-1:0]     pwdata;
    logic [RW/8-1:0]   pstrb;
    logic              pready;
    logic [RW-1:0]     prdata;
    logic              pslverr;
    logic [3:0]        wait_states;

    integer seed;
    int     errors;
    int     err_mark;                       // Error count at test start
    int     tests_run;
    int     tests_failed;
    string  test_name;

    umi_apb_bridge #(
        .AW(AW), .DW(DW), .RW(RW), .APB_AW(APB_AW),
        .GRPOFFSET(24), .GRPAW(4), .GRPID(5)
    ) dut (
        .clk(clk), .nreset(nreset),
        .req_valid(req_valid), .req_cmd(req_cmd),
        .req_dstaddr(req_dstaddr), .req_srcaddr(req_srcaddr),
        .req_data(req_data), .req_ready(req_ready),
        .resp_valid(resp_valid), .resp_cmd(resp_cmd),
        .resp_dstaddr(resp_dstaddr), .resp_srcaddr(resp_srcaddr),
        .resp_data(resp_data), .resp_ready(resp_ready),
        .paddr(paddr), .pprot(pprot), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .pstrb(pstrb),
        .pready(pready), .prdata(prdata), .pslverr(pslverr)
    );

    apb_reg_model #(.AW(APB_AW), .RW(RW)) u_regs (
        .clk(clk), .nreset(nreset), .wait_states(wait_states),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .pstrb(pstrb),
        .pready(pready), .prdata(prdata), .pslverr(pslverr)
    );

    always #10 clk = ~clk;                  // 20 ns period

    // ##########################################################################
    // Helpers and compare tasks
    // ##########################################################################

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic [AW-1:0] reg_addr(input logic [AW-1:0] base, input int idx);
        return base | (AW'(idx) << 3);      // Word index in bits 6:3
    endfunction

    function automatic umi_cmd_t make_cmd(input logic [4:0] opcode);
        umi_cmd_t c;
        c        = '0;
        c.opcode = opcode;
        c.size   = 3'd3;                    // 8-byte word
        c.qos    = 4'h6;
        c.prot   = PROT;
        c.eom    = 1'b1;
        c.eof    = 1'b1;
        c.user   = 2'b10;
        c.hostid = 3'd4;
        return c;
    endfunction

    task automatic fail(input string msg);
        $display("%s: %s", test_name, msg);
        errors++;
    endtask

    task automatic check_cmd(input string what, input umi_cmd_t exp, input umi_cmd_t act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input string what, input logic [AW-1:0] exp,
                              input logic [AW-1:0] act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_data(input string what, input logic [DW-1:0] exp,
                              input logic [DW-1:0] act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_prot(input string what, input logic [2:0] exp,
                              input logic [2:0] act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_strb(input string what, input logic [RW/8-1:0] exp,
                              input logic [RW/8-1:0] act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    // APB side fields of every completing transfer, mid-cycle
    always @(negedge clk) begin
        if (nreset && psel && penable && pready) begin
            check_prot("pprot", {1'b0, PROT}, pprot);
            check_strb("pstrb", '1, pstrb);
        end
    end

    task automatic start_test(input string name, input logic [3:0] waits);
        test_name   = name;
        wait_states = waits;
        err_mark    = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
            $display("%-14s failed with %0d errors", test_name, errors - err_mark);
        end else begin
            $display("%-14s ok", test_name);
        end
    endtask

    // ##########################################################################
    // UMI request and response handshakes entered 2 ns after an edge
    // ##########################################################################

    task automatic send_req(input umi_cmd_t cmd, input logic [AW-1:0] dst,
                            input logic [RW-1:0] data);
        int n;
        n           = 0;
        req_valid   = 1'b1;
        req_cmd     = cmd;
        req_dstaddr = dst;
        req_srcaddr = HOST;
        req_data    = {rand64(), data};     // Upper lane is noise
        while (!req_ready && n < TIMEOUT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!req_ready)
            fail("request not accepted within timeout");
        @(posedge clk);                     // Transfer edge
        #2;
        req_valid = 1'b0;
    endtask

    // Expected response follows the request with opcode, err and addresses rewritten
    task automatic check_resp(input umi_cmd_t cmd, input logic [AW-1:0] dst,
                              input logic [DW-1:0] exp_data, input logic [1:0] exp_err);
        int       n;
        umi_cmd_t exp_cmd;
        exp_cmd        = cmd;
        exp_cmd.opcode = (cmd.opcode == UMI_REQ_READ) ? UMI_RESP_READ : UMI_RESP_WRITE;
        exp_cmd.err    = exp_err;
        n              = 0;
        resp_ready     = 1'b1;
        while (!resp_valid && n < TIMEOUT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!resp_valid) begin
            fail("no response within timeout");
        end else begin
            check_cmd("resp_cmd", exp_cmd, resp_cmd);
            check_addr("resp_dstaddr", HOST, resp_dstaddr);
            check_addr("resp_srcaddr", dst, resp_srcaddr);
            check_data("resp_data", exp_data, resp_data);
            @(posedge clk);                 // Response taken here
            #2;
        end
        resp_ready = 1'b0;
    endtask

    task automatic expect_no_resp();
        bit seen;
        seen = 1'b0;
        for (int n = 0; n < TIMEOUT; n++) begin
            if (resp_valid)
                seen = 1'b1;
            @(posedge clk);
            #2;
        end
        if (seen)
            fail("unexpected response appeared");
    endtask

    // Hold resp_ready low and require a waiting response to stay frozen
    task automatic stall_resp(input int cycles);
        umi_cmd_t      last_cmd;
        logic [DW-1:0] last_data;
        logic          last_valid;
        last_cmd   = '0;
        last_data  = '0;
        last_valid = 1'b0;
        resp_ready = 1'b0;
        repeat (cycles) begin
            if (last_valid && !(resp_valid && resp_cmd === last_cmd && resp_data === last_data))
                fail("response changed while resp_ready was low");
            last_valid = resp_valid;
            last_cmd   = resp_cmd;
            last_data  = resp_data;
            @(posedge clk);
            #2;
        end
        if (!resp_valid)
            fail("no response was waiting during back-pressure");
    endtask

    // ##########################################################################
    // Directed tests
    // ##########################################################################

    task automatic write_then_read();
        logic [RW-1:0] d;
        logic [AW-1:0] a;
        start_test("write_read", 4'd0);
        d = rand64();
        a = reg_addr(BASE, 2);
        send_req(make_cmd(UMI_REQ_WRITE), a, d);
        check_resp(make_cmd(UMI_REQ_WRITE), a, '0, 2'b00);
        send_req(make_cmd(UMI_REQ_READ), a, '0);
        check_resp(make_cmd(UMI_REQ_READ), a, DW'(d), 2'b00);
        end_test();
    endtask

    task automatic posted_write_silent();
        logic [RW-1:0] d;
        logic [AW-1:0] a;
        start_test("posted_write", 4'd1);
        d = rand64();
        a = reg_addr(BASE, 6);
        send_req(make_cmd(UMI_REQ_POSTED), a, d);
        expect_no_resp();                   // Posted writes stay silent
        send_req(make_cmd(UMI_REQ_READ), a, '0);
        check_resp(make_cmd(UMI_REQ_READ), a, DW'(d), 2'b00);
        end_test();
    endtask

    task automatic slave_error_read();
        logic [AW-1:0] a;
        start_test("slave_error", 4'd2);
        a = reg_addr(BASE, 1) | 64'h80;     // Bit 7 set makes the model error
        send_req(make_cmd(UMI_REQ_READ), a, '0);
        check_resp(make_cmd(UMI_REQ_READ), a, '0, 2'b10);
        end_test();
    endtask

    task automatic dropped_requests();
        logic [RW-1:0] old_d;
        logic [RW-1:0] new_d;
        logic [AW-1:0] a;
        start_test("dropped", 4'd0);
        old_d = rand64();
        new_d = ~old_d;
        a     = reg_addr(BASE, 9);
        send_req(make_cmd(UMI_REQ_WRITE), a, old_d);
        check_resp(make_cmd(UMI_REQ_WRITE), a, '0, 2'b00);
        send_req(make_cmd(UMI_REQ_ATOMIC), a, new_d);
        send_req(make_cmd(UMI_REQ_RDMA), a, new_d);
        send_req(make_cmd(UMI_REQ_WRITE), reg_addr(OTHER, 9), new_d); // Wrong group
        expect_no_resp();
        send_req(make_cmd(UMI_REQ_READ), a, '0);
        check_resp(make_cmd(UMI_REQ_READ), a, DW'(old_d), 2'b00);
        end_test();
    endtask

    task automatic backpressure_order();
        logic [RW-1:0] d4;
        logic [RW-1:0] d5;
        logic [AW-1:0] a4;
        logic [AW-1:0] a5;
        start_test("backpressure", 4'd3);
        d4 = rand64();
        d5 = rand64();
        a4 = reg_addr(BASE, 4);
        a5 = reg_addr(BASE, 5);
        fork
            begin                           // Requester issues back to back
                send_req(make_cmd(UMI_REQ_WRITE), a4, d4);
                send_req(make_cmd(UMI_REQ_READ), a4, '0);
                send_req(make_cmd(UMI_REQ_WRITE), a5, d5);
                send_req(make_cmd(UMI_REQ_READ), a5, '0);
            end
            begin                           // Consumer stalls first
                stall_resp(10);
                check_resp(make_cmd(UMI_REQ_WRITE), a4, '0, 2'b00);
                check_resp(make_cmd(UMI_REQ_READ), a4, DW'(d4), 2'b00);
                check_resp(make_cmd(UMI_REQ_WRITE), a5, '0, 2'b00);
                check_resp(make_cmd(UMI_REQ_READ), a5, DW'(d5), 2'b00);
            end
        join
        end_test();
    endtask

    initial begin
        seed         = 77416;
        errors       = 0;
        err_mark     = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "reset";
        clk          = 1'b0;
        nreset       = 1'b0;
        req_valid    = 1'b0;
        req_cmd      = '0;
        req_dstaddr  = '0;
        req_srcaddr  = '0;
        req_data     = '0;
        resp_ready   = 1'b0;
        wait_states  = '0;
        repeat (8) @(posedge clk);          // Reset for 8 cycles
        #2;
        nreset = 1'b1;

        write_then_read();
        posted_write_silent();
        slave_error_read();
        dropped_requests();
        backpressure_order();

        $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule : tb_umi_apb_bridge

`default_nettype wire

/* umi_apb_bridge.f */
rtl/umi_apb_pkg.sv
rtl/umi_bridge_if.sv
rtl/umi_req_decode.sv
rtl/apb_access.sv
rtl/umi_resp_pack.sv
rtl/umi_apb_bridge.sv
testbench/apb_reg_model.sv
testbench/tb_umi_apb_bridge.sv
